// File: Bender.yml
package:
  name: cam_bist
  authors: []

dependencies: {}

sources:
  - hw/cam_bist_pkg.sv
  - hw/cam_bist_sequencer.sv
  - hw/cam_bist_inhandler.sv
  - hw/cam_array.sv
  - hw/cam_bist_checker.sv
  - hw/cam_bist_top.sv
  - target: test
    files:
      - tb/cam_bist_tb.sv

// File: cam_bist_top.f
hw/cam_bist_pkg.sv
hw/cam_bist_sequencer.sv
hw/cam_bist_inhandler.sv
hw/cam_array.sv
hw/cam_bist_checker.sv
hw/cam_bist_top.sv
tb/cam_bist_tb.sv

// File: hw/cam_array.sv
// Binary CAM storage with write, registered parallel search and stuck-at fault injection
`default_nettype none

module cam_array
   import cam_bist_pkg::*;
#(
   parameter int unsigned DATA_W = cam_bist_pkg::DATA_W,
   parameter int unsigned DEPTH  = cam_bist_pkg::DEPTH
) (
   input  logic                      bist_clk,
   input  logic                      rst_b,
   input  logic                      req_valid,
   output logic                      req_ready,
   input  cam_req_t                  req,
   input  logic                      fault_en,
   input  addr_t                     fault_addr,
   input  logic [$clog2(DATA_W)-1:0] fault_bit,
   input  logic                      fault_val,
   output logic                      rsp_valid,
   output cam_rsp_t                  rsp
);

   // Stored words
   data_t            mem [DEPTH];
   // Stored words as seen by the compare logic
   data_t            view [DEPTH];
   logic [DEPTH-1:0] hit;
   logic             accept;

   // Array never stalls
   assign req_ready = 1'b1;
   assign accept    = req_valid && req_ready;

   // --------------------------------------------------
   // Write port
   // --------------------------------------------------
   always_ff @(posedge bist_clk) begin
      if (accept && req.kind == op_write) begin
         mem[req.addr] <= req.data;
      end
   end

   // --------------------------------------------------
   // Fault overlay and match lines
   // --------------------------------------------------
   always_comb begin
      for (int i = 0; i < DEPTH; i++) begin
         view[i] = mem[i];
         // Stuck-at cell overrides whatever was written
         if (fault_en && fault_addr == addr_t'(i)) begin
            view[i][fault_bit] = fault_val;
         end
         // Full-word equality per entry
         hit[i] = (view[i] == req.data);
      end
   end

   // --------------------------------------------------
   // Response register
   // --------------------------------------------------
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         rsp_valid <= 1'b0;
      end else begin
         rsp_valid <= accept;
      end
   end

   always_ff @(posedge bist_clk) begin
      if (accept) begin
         // Writes come back flagged as non-search
         rsp.srch     <= (req.kind == op_search);
         rsp.match    <= hit;
         rsp.mask_en  <= req.mask_en;
         rsp.srch_idx <= req.srch_idx;
      end
   end

endmodule

`default_nettype wire

// File: hw/cam_bist_checker.sv
// Match vector checker with fail counter, first failing search index and sticky fail flag
`default_nettype none

module cam_bist_checker
   import cam_bist_pkg::*;
#(
   parameter int unsigned DEPTH = cam_bist_pkg::DEPTH
) (
   input  logic      bist_clk,
   input  logic      rst_b,
   input  logic      rsp_valid,
   input  cam_rsp_t  rsp,
   input  logic      start,
   output logic      fail,
   output fail_cnt_t fail_cnt,
   output srch_idx_t first_fail
);

   logic [DEPTH-1:0] exp_match;
   logic             mismatch;

   // --------------------------------------------------
   // Expected vector
   // --------------------------------------------------
   // Unmasked key equals every entry while a masked key equals none
   assign exp_match = rsp.mask_en ? '0 : '1;

   // Writes never count
   assign mismatch = rsp_valid && rsp.srch && (rsp.match != match_t'(exp_match));

   // --------------------------------------------------
   // Result registers
   // --------------------------------------------------
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         fail       <= 1'b0;
         fail_cnt   <= '0;
         first_fail <= '0;
      end else if (start) begin
         // A new run forgets previous results
         fail       <= 1'b0;
         fail_cnt   <= '0;
         first_fail <= '0;
      end else if (mismatch) begin
         fail_cnt <= fail_cnt + 1'b1;
         // Only the first failing search is kept
         if (!fail) begin
            first_fail <= rsp.srch_idx;
            fail       <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: hw/cam_bist_inhandler.sv
// BIST input handler stage with rotating compare mask, data inversion and key register
`default_nettype none

module cam_bist_inhandler
   import cam_bist_pkg::*;
#(
   parameter int unsigned DATA_W = cam_bist_pkg::DATA_W
) (
   input  logic     bist_clk,
   input  logic     rst_b,
   input  logic     op_valid,
   output logic     op_ready,
   input  bist_op_t op,
   output logic     req_valid,
   input  logic     req_ready,
   output cam_req_t req
);

   // One-hot mask selecting the bit flipped by a masked search
   logic [DATA_W-1:0] mask;
   data_t             inv_data;
   data_t             key;
   logic              take;

   // Register slot free or draining this cycle
   assign op_ready = !req_valid || req_ready;
   assign take     = op_valid && op_ready;

   // --------------------------------------------------
   // Compare data generation
   // --------------------------------------------------
   // Pass bit flips the whole background
   assign inv_data = op.wr_data ^ {DATA_W{op.inv}};
   // Masked search flips one bit so no entry should match
   assign key      = inv_data ^ (mask & {DATA_W{op.mask_en}});

   // --------------------------------------------------
   // Mask rotation
   // --------------------------------------------------
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         mask <= DATA_W'(1);
      end else if (take && op.kind == op_search && op.mask_en && op.rotate) begin
         // Shift left with the MSB wrapping into bit 0
         mask <= {mask[DATA_W-2:0], mask[DATA_W-1]};
      end
   end

   // --------------------------------------------------
   // Output register stage
   // --------------------------------------------------
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         req_valid <= 1'b0;
      end else if (take) begin
         req_valid <= 1'b1;
      end else if (req_ready) begin
         req_valid <= 1'b0;
      end
   end

   always_ff @(posedge bist_clk) begin
      if (take) begin
         req.kind     <= op.kind;
         req.addr     <= op.addr;
         // Writes store the plain inverted word
         req.data     <= (op.kind == op_write) ? inv_data : key;
         req.mask_en  <= op.mask_en;
         req.srch_idx <= op.srch_idx;
      end
   end

endmodule

`default_nettype wire

// File: hw/cam_bist_pkg.sv
// Widths, word types, op/request/response structs and sequencer state enum
`default_nettype none

package cam_bist_pkg;

   // --------------------------------------------------
   // Default sizes
   // --------------------------------------------------
   // Bits per CAM word
   localparam int unsigned DATA_W = 16;
   // Number of CAM entries
   localparam int unsigned DEPTH  = 8;

   // --------------------------------------------------
   // Plain vector types
   // --------------------------------------------------
   typedef logic [DATA_W-1:0] data_t;
   // One hit bit per entry
   typedef logic [DEPTH-1:0]  match_t;
   typedef logic [2:0]        addr_t;
   // Covers 2*(DATA_W+1) searches of both passes
   typedef logic [5:0]        srch_idx_t;
   typedef logic [5:0]        fail_cnt_t;

   typedef enum logic {
      op_write,
      op_search
   } op_kind_t;

   // --------------------------------------------------
   // Stage payloads
   // --------------------------------------------------
   // Sequencer to input handler
   typedef struct packed {
      op_kind_t  kind;
      addr_t     addr;
      // Background word, not yet inverted
      data_t     wr_data;
      // Pass bit selecting the inverted background
      logic      inv;
      logic      mask_en;
      // Step the one-hot mask after this search
      logic      rotate;
      srch_idx_t srch_idx;
   } bist_op_t;

   // Input handler to CAM array
   typedef struct packed {
      op_kind_t  kind;
      addr_t     addr;
      // Write word or compare key
      data_t     data;
      logic      mask_en;
      srch_idx_t srch_idx;
   } cam_req_t;

   // CAM array to checker
   typedef struct packed {
      // Set only for search responses
      logic      srch;
      match_t    match;
      logic      mask_en;
      srch_idx_t srch_idx;
   } cam_rsp_t;

   typedef enum logic [2:0] {
      s_idle,
      s_write,
      s_search_unmasked,
      s_search_masked,
      s_done
   } seq_state_t;

endpackage

`default_nettype wire

// File: hw/cam_bist_sequencer.sv
// Test sequencer FSM issuing write and search ops over a true and an inverted pass
`default_nettype none

module cam_bist_sequencer
   import cam_bist_pkg::*;
#(
   parameter int unsigned DATA_W = cam_bist_pkg::DATA_W,
   parameter int unsigned DEPTH  = cam_bist_pkg::DEPTH
) (
   input  logic     bist_clk,
   input  logic     rst_b,
   input  logic     start,
   input  data_t    bg_pattern,
   output logic     op_valid,
   input  logic     op_ready,
   output bist_op_t op,
   output logic     done
);

   localparam int unsigned BIT_W = $clog2(DATA_W);
   localparam addr_t LAST_ADDR = addr_t'(DEPTH - 1);
   localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(DATA_W - 1);

   seq_state_t       state;
   logic             pass;
   addr_t            entry_cnt;
   logic [BIT_W-1:0] bit_cnt;
   srch_idx_t        srch_idx;
   // Counts cycles while the pipeline drains
   logic [1:0]       drain_cnt;
   data_t            bg_q;
   logic             fire;

   assign fire = op_valid && op_ready;

   // --------------------------------------------------
   // State and counters
   // --------------------------------------------------
   always_ff @(posedge bist_clk) begin
      if (!rst_b) begin
         state     <= s_idle;
         pass      <= 1'b0;
         entry_cnt <= '0;
         bit_cnt   <= '0;
         srch_idx  <= '0;
         drain_cnt <= '0;
      end else begin
         unique case (state)
            s_idle: begin
               // Start only matters here
               if (start) begin
                  state     <= s_write;
                  pass      <= 1'b0;
                  entry_cnt <= '0;
                  bit_cnt   <= '0;
                  srch_idx  <= '0;
               end
            end
            s_write: begin
               if (fire) begin
                  if (entry_cnt == LAST_ADDR) begin
                     entry_cnt <= '0;
                     state     <= s_search_unmasked;
                  end else begin
                     entry_cnt <= entry_cnt + 1'b1;
                  end
               end
            end
            s_search_unmasked: begin
               // Single full-word compare that every entry should hit
               if (fire) begin
                  srch_idx <= srch_idx + 1'b1;
                  state    <= s_search_masked;
               end
            end
            s_search_masked: begin
               if (fire) begin
                  srch_idx <= srch_idx + 1'b1;
                  if (bit_cnt == LAST_BIT) begin
                     bit_cnt <= '0;
                     // Second pass ends the run
                     if (pass) begin
                        state     <= s_done;
                        drain_cnt <= '0;
                     end else begin
                        pass  <= 1'b1;
                        state <= s_write;
                     end
                  end else begin
                     bit_cnt <= bit_cnt + 1'b1;
                  end
               end
            end
            s_done: begin
               if (drain_cnt == 2'd3) begin
                  state <= s_idle;
               end else begin
                  drain_cnt <= drain_cnt + 1'b1;
               end
            end
            default: state <= s_idle;
         endcase
      end
   end

   // Background captured once per run
   always_ff @(posedge bist_clk) begin
      if (state == s_idle && start) begin
         bg_q <= bg_pattern;
      end
   end

   // --------------------------------------------------
   // Operation output
   // --------------------------------------------------
   assign op_valid = (state == s_write) || (state == s_search_unmasked) ||
                     (state == s_search_masked);

   always_comb begin
      op          = '0;
      op.kind     = (state == s_write) ? op_write : op_search;
      op.addr     = entry_cnt;
      op.wr_data  = bg_q;
      op.inv      = pass;
      op.mask_en  = (state == s_search_masked);
      // Every masked search steps the mask
      op.rotate   = (state == s_search_masked);
      op.srch_idx = srch_idx;
   end

   // Pulse three cycles after the last search left
   assign done = (state == s_done) && (drain_cnt == 2'd3);

endmodule

`default_nettype wire

// File: hw/cam_bist_top.sv
// CAM BIST top level chaining sequencer, input handler, CAM array and checker
`default_nettype none

module cam_bist_top
   import cam_bist_pkg::*;
#(
   parameter int unsigned DATA_W = cam_bist_pkg::DATA_W,
   parameter int unsigned DEPTH  = cam_bist_pkg::DEPTH
) (
   input  logic                      bist_clk,
   input  logic                      rst_b,
   input  logic                      start,
   input  data_t                     bg_pattern,
   input  logic                      fault_en,
   input  addr_t                     fault_addr,
   input  logic [$clog2(DATA_W)-1:0] fault_bit,
   input  logic                      fault_val,
   output logic                      done,
   output logic                      fail,
   output fail_cnt_t                 fail_cnt,
   output srch_idx_t                 first_fail
);

   // --------------------------------------------------
   // Stage links
   // --------------------------------------------------
   logic     op_valid;
   logic     op_ready;
   bist_op_t op;
   logic     req_valid;
   logic     req_ready;
   cam_req_t req;
   logic     rsp_valid;
   cam_rsp_t rsp;

   cam_bist_sequencer #(
      .DATA_W (DATA_W),
      .DEPTH  (DEPTH)
   ) u_sequencer (
      .bist_clk   (bist_clk),
      .rst_b      (rst_b),
      .start      (start),
      .bg_pattern (bg_pattern),
      .op_valid   (op_valid),
      .op_ready   (op_ready),
      .op         (op),
      .done       (done)
   );

   cam_bist_inhandler #(
      .DATA_W (DATA_W)
   ) u_inhandler (
      .bist_clk  (bist_clk),
      .rst_b     (rst_b),
      .op_valid  (op_valid),
      .op_ready  (op_ready),
      .op        (op),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .req       (req)
   );

   cam_array #(
      .DATA_W (DATA_W),
      .DEPTH  (DEPTH)
   ) u_cam_array (
      .bist_clk   (bist_clk),
      .rst_b      (rst_b),
      .req_valid  (req_valid),
      .req_ready  (req_ready),
      .req        (req),
      .fault_en   (fault_en),
      .fault_addr (fault_addr),
      .fault_bit  (fault_bit),
      .fault_val  (fault_val),
      .rsp_valid  (rsp_valid),
      .rsp        (rsp)
   );

   // Start also clears the previous results
   cam_bist_checker #(
      .DEPTH (DEPTH)
   ) u_checker (
      .bist_clk   (bist_clk),
      .rst_b      (rst_b),
      .rsp_valid  (rsp_valid),
      .rsp        (rsp),
      .start      (start),
      .fail       (fail),
      .fail_cnt   (fail_cnt),
      .first_fail (first_fail)
   );

endmodule

`default_nettype wire

// File: tb/cam_bist_tb.sv
// CAM BIST testbench with clock, reset, LFSR stimulus, fault model, compare tasks and watchdog
`default_nettype none

module cam_bist_tb
   import cam_bist_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int unsigned BIT_W = $clog2(DATA_W);
   localparam int CLK_PERIOD = 40;
   // Cycles budgeted for one complete run
   localparam int RUN_CYC  = 2 * (DEPTH + DATA_W + 1) + 10;
   localparam int MAX_RUNS = 20;
   localparam logic [15:0] SEED = 16'd52;

   logic             bist_clk;
   logic             rst_b;
   logic             start;
   data_t            bg_pattern;
   logic             fault_en;
   addr_t            fault_addr;
   logic [BIT_W-1:0] fault_bit;
   logic             fault_val;
   logic             done;
   logic             fail;
   fail_cnt_t        fail_cnt;
   srch_idx_t        first_fail;

   logic [15:0]      lfsr;
   int               cyc = 0;
   // Cycle stamps of the first and second count increment
   int               t_one;
   int               t_two;
   fail_cnt_t        prev_cnt = '0;

   cam_bist_top #(
      .DATA_W (DATA_W),
      .DEPTH  (DEPTH)
   ) u_cam_bist_top (
      .bist_clk   (bist_clk),
      .rst_b      (rst_b),
      .start      (start),
      .bg_pattern (bg_pattern),
      .fault_en   (fault_en),
      .fault_addr (fault_addr),
      .fault_bit  (fault_bit),
      .fault_val  (fault_val),
      .done       (done),
      .fail       (fail),
      .fail_cnt   (fail_cnt),
      .first_fail (first_fail)
   );

   initial begin
      bist_clk = 1'b0;
      forever #(CLK_PERIOD / 2) bist_clk = ~bist_clk;
   end

   // Whole-test time limit
   initial begin
      #(MAX_RUNS * RUN_CYC * CLK_PERIOD);
      $display("RESULT: FAIL");
      $fatal(1, "Watchdog expired, the tests did not finish in time");
   end

   // --------------------------------------------------
   // Count monitor sampled away from the active edge
   // --------------------------------------------------
   always @(negedge bist_clk) begin
      cyc = cyc + 1;
      if (fail_cnt != prev_cnt) begin
         if (fail_cnt == fail_cnt_t'(1)) t_one = cyc;
         if (fail_cnt == fail_cnt_t'(2)) t_two = cyc;
      end
      prev_cnt = fail_cnt;
   end

   // Taps 16,14,13,11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // One LFSR step per bit
   task automatic take_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
   endtask

   // --------------------------------------------------
   // Compare tasks
   // --------------------------------------------------
   task automatic check_cnt(input fail_cnt_t got, input fail_cnt_t exp, input string what);
      if (got !== exp) begin
         $display("FAIL %0t ns: %s, got %0d expected %0d", $time, what, got, exp);
         $display("RESULT: FAIL");
         $fatal(1, "Stopped at first mismatch");
      end
   endtask

   task automatic check_idx(input srch_idx_t got, input srch_idx_t exp, input string what);
      if (got !== exp) begin
         $display("FAIL %0t ns: %s, got %0d expected %0d", $time, what, got, exp);
         $display("RESULT: FAIL");
         $fatal(1, "Stopped at first mismatch");
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("FAIL %0t ns: %s, got %b expected %b", $time, what, got, exp);
         $display("RESULT: FAIL");
         $fatal(1, "Stopped at first mismatch");
      end
   endtask

   // --------------------------------------------------
   // One BIST run with model prediction
   // --------------------------------------------------
   task automatic run_bist(input data_t bg, input logic fen, input addr_t fa,
                           input logic [BIT_W-1:0] fb, input logic fv);
      int        waited;
      logic      late_pass;
      srch_idx_t exp_first;
      srch_idx_t exp_second;
      srch_idx_t got_second;
      waited = 0;
      // Stuck value equal to the background only shows in the inverted pass
      late_pass  = (bg[fb] == fv);
      exp_first  = late_pass ? srch_idx_t'(DATA_W + 1) : srch_idx_t'(0);
      // Masked search k of a pass flips bit k
      exp_second = exp_first + srch_idx_t'(1) + srch_idx_t'(fb);
      @(posedge bist_clk);
      t_one = -1;
      t_two = -1;
      bg_pattern <= bg;
      fault_en   <= fen;
      fault_addr <= fa;
      fault_bit  <= fb;
      fault_val  <= fv;
      start      <= 1'b1;
      @(posedge bist_clk);
      start <= 1'b0;
      @(negedge bist_clk);
      check_cnt(fail_cnt, '0, "count not cleared by start");
      check_idx(first_fail, '0, "first fail not cleared by start");
      check_flag(fail, 1'b0, "fail not cleared by start");
      while (!done && waited < RUN_CYC) begin
         @(negedge bist_clk);
         waited++;
      end
      if (!done) begin
         $display("RESULT: FAIL");
         $fatal(1, "The done pulse did not arrive within %0d cycles", RUN_CYC);
      end
      if (fen) begin
         check_cnt(fail_cnt, fail_cnt_t'(2), "fault run count");
         check_flag(fail, 1'b1, "fault run fail flag");
         check_idx(first_fail, exp_first, "fault run first failing search");
         // Searches issue one per cycle, so the gap gives the second index
         got_second = first_fail + srch_idx_t'(t_two - t_one);
         check_idx(got_second, exp_second, "masked search that caught the fault");
      end else begin
         check_cnt(fail_cnt, '0, "clean run count");
         check_flag(fail, 1'b0, "clean run fail flag");
         check_idx(first_fail, '0, "clean run first fail");
      end
   endtask

   // --------------------------------------------------
   // Test sequence
   // --------------------------------------------------
   initial begin
      logic [31:0]      r;
      logic [31:0]      s;
      logic [BIT_W-1:0] b;
      addr_t            a;
      rst_b      = 1'b0;
      start      = 1'b0;
      bg_pattern = '0;
      fault_en   = 1'b0;
      fault_addr = '0;
      fault_bit  = '0;
      fault_val  = 1'b0;
      lfsr       = SEED;
      repeat (5) @(posedge bist_clk);
      rst_b <= 1'b1;
      @(negedge bist_clk);
      check_flag(fail, 1'b0, "fail after reset");
      check_cnt(fail_cnt, '0, "count after reset");
      // Clean runs with random backgrounds
      for (int i = 0; i < 2; i++) begin
         take_bits(DATA_W, r);
         run_bist(data_t'(r), 1'b0, '0, '0, 1'b0);
      end
      // Stuck value opposite to the background bit
      for (int i = 0; i < 3; i++) begin
         take_bits(DATA_W, r);
         take_bits(3, s);
         a = addr_t'(s);
         take_bits(BIT_W, s);
         b = s[BIT_W-1:0];
         run_bist(data_t'(r), 1'b1, a, b, ~r[b]);
      end
      // Stuck value equal to the background bit
      for (int i = 0; i < 3; i++) begin
         take_bits(DATA_W, r);
         take_bits(3, s);
         a = addr_t'(s);
         take_bits(BIT_W, s);
         b = s[BIT_W-1:0];
         run_bist(data_t'(r), 1'b1, a, b, r[b]);
      end
      // Corner entries and bits exercising the mask wrap
      for (int i = 0; i < 6; i++) begin
         take_bits(DATA_W, r);
         take_bits(3, s);
         a = s[0] ? addr_t'(DEPTH - 1) : addr_t'(0);
         b = s[1] ? BIT_W'(DATA_W - 1) : '0;
         run_bist(data_t'(r), 1'b1, a, b, s[2]);
      end
      // Back to back after fault runs so the results must clear
      for (int i = 0; i < 2; i++) begin
         take_bits(DATA_W, r);
         run_bist(data_t'(r), 1'b0, '0, '0, 1'b0);
      end
      $display("RESULT: PASS");
      $finish;
   end

endmodule

`default_nettype wire
